// ==== hdl/reconfig_pkg.sv ====
`default_nettype none

package reconfig_pkg;

  typedef logic [7:0]  reconfig_addr_t;
  typedef logic [15:0] reconfig_data_t;

  // Writing zero here enables reconfiguration, reset value is one
  localparam reconfig_addr_t ENABLE_ADDR    = 8'h00;

  // Address bit 7 selects the configuration space 0x80-0xFF
  localparam reconfig_addr_t VENDOR_ID_ADDR = 8'h89;

  // Request bus, driven by the initiator
  typedef struct packed {
    logic           chipselect;
    logic           read;
    logic           write;
    reconfig_addr_t address;
    reconfig_data_t writedata;
  } reconfig_req_t;

  // Response bus, driven by the register block
  typedef struct packed {
    logic           waitrequest;
    logic           readdatavalid;
    reconfig_data_t readdata;
  } reconfig_rsp_t;

  typedef enum logic [2:0] {
    IDLE_ST         = 3'd0,
    ENABLE_ST       = 3'd1,
    READ_VENDOR_ST  = 3'd2,
    VENDOR_UPD_ST   = 3'd3,
    WRITE_VENDOR_ST = 3'd4,
    DONE_ST         = 3'd5
  } reconfig_state_t;

endpackage

`default_nettype wire

// ==== hdl/pcie_reconfig_initiator.sv ====
`default_nettype none

module pcie_reconfig_initiator (
  input  logic                        pcie_reconfig_clk,
  input  logic                        pcie_rstn,
  input  logic                        set_pcie_reconfig,
  input  reconfig_pkg::reconfig_rsp_t rsp,
  output reconfig_pkg::reconfig_req_t req,
  output logic                        pcie_reconfig_busy
);

  import reconfig_pkg::*;

  reconfig_state_t cstate;
  reconfig_state_t nstate;
  logic [2:0]      rstn_sync;
  logic            sync_rstn;

  // Three flop reset synchronizer, release comes 3 edges after pcie_rstn rises
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!pcie_rstn) begin
      rstn_sync <= 3'b000;
    end else begin
      rstn_sync <= {rstn_sync[1:0], 1'b1};
    end
  end

  assign sync_rstn = rstn_sync[2];

  // Busy until the FSM parks in the done state
  assign pcie_reconfig_busy = (cstate != DONE_ST);

  always_comb begin
    nstate = cstate;
    case (cstate)
      IDLE_ST: begin
        if (set_pcie_reconfig) begin
          nstate = ENABLE_ST;
        end else begin
          // Nothing to do, go straight to done
          nstate = DONE_ST;
        end
      end
      ENABLE_ST: begin
        if (!rsp.waitrequest) begin
          nstate = READ_VENDOR_ST;
        end
      end
      READ_VENDOR_ST: begin
        if (!rsp.waitrequest) begin
          nstate = VENDOR_UPD_ST;
        end
      end
      VENDOR_UPD_ST: begin
        // Read data arrives during this cycle
        nstate = WRITE_VENDOR_ST;
      end
      WRITE_VENDOR_ST: begin
        if (!rsp.waitrequest) begin
          nstate = DONE_ST;
        end
      end
      DONE_ST: begin
        nstate = DONE_ST;
      end
      default: begin
        nstate = IDLE_ST;
      end
    endcase
  end

  always_ff @(posedge pcie_reconfig_clk) begin
    if (!sync_rstn) begin
      cstate <= IDLE_ST;
    end else begin
      cstate <= nstate;
    end
  end

  // Request outputs are all registered
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!sync_rstn) begin
      req <= '0;
    end else begin
      if (cstate == ENABLE_ST) begin
        req.address <= ENABLE_ADDR;
      end else begin
        req.address <= VENDOR_ID_ADDR;
      end

      // Enable word is zero, the vendor ID write carries the read value plus one
      if (cstate == ENABLE_ST) begin
        req.writedata <= '0;
      end else if (rsp.readdatavalid) begin
        req.writedata <= rsp.readdata + 16'd1;
      end

      // Strobes stay up while the slave stalls and drop once it accepts
      case (cstate)
        READ_VENDOR_ST: begin
          req.chipselect <= rsp.waitrequest;
          req.read       <= rsp.waitrequest;
          req.write      <= 1'b0;
        end
        ENABLE_ST, WRITE_VENDOR_ST: begin
          req.chipselect <= rsp.waitrequest;
          req.read       <= 1'b0;
          req.write      <= rsp.waitrequest;
        end
        default: begin
          req.chipselect <= 1'b0;
          req.read       <= 1'b0;
          req.write      <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reconfig_register_block.sv ====
`default_nettype none

module reconfig_register_block #(
  parameter reconfig_pkg::reconfig_data_t DEFAULT_VENDOR_ID = 16'h1172,
  parameter logic [2:0]                   MAX_WAIT          = 3'd4
) (
  input  logic                         pcie_reconfig_clk,
  input  logic                         pcie_rstn,
  input  reconfig_pkg::reconfig_req_t  req,
  output reconfig_pkg::reconfig_rsp_t  rsp,
  output reconfig_pkg::reconfig_data_t vendor_id,
  output logic                         reconfig_enabled
);

  import reconfig_pkg::*;

  localparam int CFG_WORDS = 128;

  reconfig_data_t enable_q;
  reconfig_data_t cfg_mem [CFG_WORDS];
  logic [2:0]     lfsr;
  logic [2:0]     wait_cnt;
  logic           active;
  logic           accept;
  logic           cfg_hit;
  reconfig_data_t rd_word;
  logic           rvalid_q;
  reconfig_data_t rdata_q;

  // Free running LFSR, x^3 + x^2 + 1, never reaches zero from a nonzero seed
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!pcie_rstn) begin
      lfsr <= 3'b101;
    end else begin
      lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
    end
  end

  // The first cycle chipselect is seen counts as one wait cycle, then
  // the counter adds up to MAX_WAIT-1 more before the access is taken
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!pcie_rstn) begin
      active   <= 1'b0;
      wait_cnt <= 3'd0;
    end else if (!req.chipselect || accept) begin
      active   <= 1'b0;
    end else if (!active) begin
      active   <= 1'b1;
      wait_cnt <= lfsr % MAX_WAIT;
    end else begin
      wait_cnt <= wait_cnt - 3'd1;
    end
  end

  assign accept  = req.chipselect && active && (wait_cnt == 3'd0);
  assign cfg_hit = req.address[7];

  // Enable register and configuration array
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!pcie_rstn) begin
      enable_q <= 16'h0001;
      for (int i = 0; i < CFG_WORDS; i++) begin
        if (i == int'(VENDOR_ID_ADDR[6:0])) begin
          cfg_mem[i] <= DEFAULT_VENDOR_ID;
        end else begin
          cfg_mem[i] <= '0;
        end
      end
    end else if (accept && req.write) begin
      if (req.address == ENABLE_ADDR) begin
        enable_q <= req.writedata;
      end else if (cfg_hit && !enable_q[0]) begin
        // Configuration space is writable only while reconfiguration is enabled
        cfg_mem[req.address[6:0]] <= req.writedata;
      end
    end
  end

  always_comb begin
    if (cfg_hit) begin
      rd_word = cfg_mem[req.address[6:0]];
    end else if (req.address == ENABLE_ADDR) begin
      rd_word = enable_q;
    end else begin
      rd_word = '0;
    end
  end

  // Read data comes back one cycle after the acceptance cycle
  always_ff @(posedge pcie_reconfig_clk) begin
    if (!pcie_rstn) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept && req.read;
    end
  end

  always_ff @(posedge pcie_reconfig_clk) begin
    if (accept && req.read) begin
      rdata_q <= rd_word;
    end
  end

  assign rsp.waitrequest   = !accept;
  assign rsp.readdatavalid = rvalid_q;
  assign rsp.readdata      = rdata_q;

  assign vendor_id        = cfg_mem[VENDOR_ID_ADDR[6:0]];
  assign reconfig_enabled = !enable_q[0];

endmodule

`default_nettype wire

// ==== hdl/pcie_reconfig_top.sv ====
`default_nettype none

module pcie_reconfig_top #(
  parameter reconfig_pkg::reconfig_data_t DEFAULT_VENDOR_ID = 16'h1172,
  parameter logic [2:0]                   MAX_WAIT          = 3'd4
) (
  input  logic                         pcie_reconfig_clk,
  input  logic                         pcie_rstn,
  input  logic                         set_pcie_reconfig,
  output logic                         pcie_reconfig_busy,
  output reconfig_pkg::reconfig_data_t vendor_id,
  output logic                         reconfig_enabled
);

  import reconfig_pkg::*;

  reconfig_req_t req;
  reconfig_rsp_t rsp;

  // Master side, resets through its own synchronizer
  pcie_reconfig_initiator u_initiator (
    .pcie_reconfig_clk  (pcie_reconfig_clk),
    .pcie_rstn          (pcie_rstn),
    .set_pcie_reconfig  (set_pcie_reconfig),
    .rsp                (rsp),
    .req                (req),
    .pcie_reconfig_busy (pcie_reconfig_busy)
  );

  // Slave side, models the hard IP register space
  reconfig_register_block #(
    .DEFAULT_VENDOR_ID (DEFAULT_VENDOR_ID),
    .MAX_WAIT          (MAX_WAIT)
  ) u_regs (
    .pcie_reconfig_clk (pcie_reconfig_clk),
    .pcie_rstn         (pcie_rstn),
    .req               (req),
    .rsp               (rsp),
    .vendor_id         (vendor_id),
    .reconfig_enabled  (reconfig_enabled)
  );

endmodule

`default_nettype wire

// ==== verification/pcie_reconfig_chk.sv ====
`default_nettype none

module pcie_reconfig_chk (
  input logic                          pcie_reconfig_clk,
  input logic                          sync_rstn,
  input reconfig_pkg::reconfig_req_t   req,
  input reconfig_pkg::reconfig_rsp_t   rsp,
  input reconfig_pkg::reconfig_state_t cstate,
  input logic                          pcie_reconfig_busy
);

  timeunit 1ns;
  timeprecision 1ps;

  import reconfig_pkg::*;

  // Sticky flags, one per assertion, the testbench polls their OR
  logic rd_wr_bad     = 1'b0;
  logic cs_bad        = 1'b0;
  logic hold_bad      = 1'b0;
  logic busy_rise_bad = 1'b0;
  logic done_cs_bad   = 1'b0;
  logic any_failed;

  assign any_failed = rd_wr_bad | cs_bad | hold_bad | busy_rise_bad | done_cs_bad;

  a_no_rd_wr: assert property (@(posedge pcie_reconfig_clk) disable iff (!sync_rstn)
    !(req.read && req.write))
  else begin
    rd_wr_bad = 1'b1;
    $error("read and write strobes are high together");
  end

  a_cs_strobe: assert property (@(posedge pcie_reconfig_clk) disable iff (!sync_rstn)
    req.chipselect |-> (req.read || req.write))
  else begin
    cs_bad = 1'b1;
    $error("chipselect is high without a read or write strobe");
  end

  // A stalled request must not change until the slave accepts it
  a_req_hold: assert property (@(posedge pcie_reconfig_clk) disable iff (!sync_rstn)
    (req.chipselect && rsp.waitrequest) |=> $stable(req))
  else begin
    hold_bad = 1'b1;
    $error("request changed while waitrequest was high");
  end

  a_busy_rise: assert property (@(posedge pcie_reconfig_clk)
    $rose(pcie_reconfig_busy) |-> !$past(sync_rstn))
  else begin
    busy_rise_bad = 1'b1;
    $error("busy rose without a reset");
  end

  a_done_quiet: assert property (@(posedge pcie_reconfig_clk) disable iff (!sync_rstn)
    (cstate == DONE_ST) |-> !req.chipselect)
  else begin
    done_cs_bad = 1'b1;
    $error("chipselect is high in the done state");
  end

endmodule

bind pcie_reconfig_initiator pcie_reconfig_chk u_chk (
  .pcie_reconfig_clk  (pcie_reconfig_clk),
  .sync_rstn          (sync_rstn),
  .req                (req),
  .rsp                (rsp),
  .cstate             (cstate),
  .pcie_reconfig_busy (pcie_reconfig_busy)
);

`default_nettype wire

// ==== verification/pcie_reconfig_tb.sv ====
`default_nettype none

module pcie_reconfig_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import reconfig_pkg::*;

  localparam reconfig_data_t DEFAULT_VENDOR_ID = 16'h1172;
  localparam int NUM_EPISODES = 40;
  localparam int BUSY_TIMEOUT = 200;
  localparam int HOLD_CYCLES  = 20;

  logic           pcie_reconfig_clk;
  logic           pcie_rstn;
  logic           set_pcie_reconfig;
  logic           pcie_reconfig_busy;
  reconfig_data_t vendor_id;
  logic           reconfig_enabled;

  // Reference model state
  reconfig_data_t exp_vendor_id;
  logic           exp_enabled;

  int abort_count;

  pcie_reconfig_top dut (
    .pcie_reconfig_clk  (pcie_reconfig_clk),
    .pcie_rstn          (pcie_rstn),
    .set_pcie_reconfig  (set_pcie_reconfig),
    .pcie_reconfig_busy (pcie_reconfig_busy),
    .vendor_id          (vendor_id),
    .reconfig_enabled   (reconfig_enabled)
  );

  initial begin
    pcie_reconfig_clk = 1'b0;
    forever #20 pcie_reconfig_clk = ~pcie_reconfig_clk;
  end

  task automatic report_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      report_failure();
    end
  endtask

  task automatic check_assertions();
    if (dut.u_initiator.u_chk.any_failed === 1'b1) begin
      $display("A concurrent assertion on the request bus or busy has failed");
      report_failure();
    end
  endtask

  // Outputs are sampled on the falling edge, away from the driving edge
  task automatic next_sample();
    @(negedge pcie_reconfig_clk);
    check_assertions();
  endtask

  function automatic logic random_bit();
    logic [31:0] r;
    r = $urandom;
    return r[0];
  endfunction

  task automatic model_reset();
    exp_vendor_id = DEFAULT_VENDOR_ID;
    exp_enabled   = 1'b0;
  endtask

  // A completed sequence enables reconfiguration and bumps the vendor ID
  task automatic model_finish(input logic set_bit);
    if (set_bit) begin
      exp_vendor_id = DEFAULT_VENDOR_ID + 16'd1;
      exp_enabled   = 1'b1;
    end
  endtask

  task automatic check_outputs(input logic exp_busy);
    check_value("pcie_reconfig_busy", 16'(pcie_reconfig_busy), 16'(exp_busy));
    check_value("vendor_id", vendor_id, exp_vendor_id);
    check_value("reconfig_enabled", 16'(reconfig_enabled), 16'(exp_enabled));
  endtask

  task automatic apply_reset(input int cycles, input logic set_bit);
    @(posedge pcie_reconfig_clk);
    pcie_rstn         <= 1'b0;
    set_pcie_reconfig <= set_bit;
    repeat (cycles) @(posedge pcie_reconfig_clk);
    pcie_rstn <= 1'b1;
    model_reset();
    next_sample();
    check_outputs(1'b1);
  endtask

  task automatic wait_busy_low();
    int cycles;
    cycles = 0;
    while (pcie_reconfig_busy !== 1'b0) begin
      if (cycles >= BUSY_TIMEOUT) begin
        $display("Timeout: busy did not fall within %0d cycles", BUSY_TIMEOUT);
        report_failure();
      end
      next_sample();
      cycles++;
    end
  endtask

  // Busy must stay low whatever set_pcie_reconfig does after done
  task automatic hold_after_done();
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(posedge pcie_reconfig_clk);
      set_pcie_reconfig <= random_bit();
      next_sample();
      check_outputs(1'b0);
    end
  endtask

  // The shortest full sequence needs 14 cycles after release, so 12 is still mid-flight
  task automatic abort_sequence();
    int stop_after;
    int reset_cycles;
    stop_after   = $urandom_range(12, 1);
    reset_cycles = $urandom_range(8, 4);
    abort_count++;
    apply_reset(reset_cycles, 1'b1);
    for (int i = 0; i < stop_after; i++) begin
      next_sample();
      check_value("pcie_reconfig_busy", 16'(pcie_reconfig_busy), 16'd1);
    end
  endtask

  task automatic run_episode(input int reset_cycles, input logic set_bit);
    apply_reset(reset_cycles, set_bit);
    wait_busy_low();
    model_finish(set_bit);
    check_outputs(1'b0);
    hold_after_done();
  endtask

  initial begin
    int reset_cycles;
    logic set_bit;
    void'($urandom(32'h2361));
    pcie_rstn         = 1'b0;
    set_pcie_reconfig = 1'b0;
    abort_count       = 0;
    model_reset();

    for (int ep = 0; ep < NUM_EPISODES; ep++) begin
      if (ep > 0 && $urandom_range(3, 0) == 0) begin
        abort_sequence();
      end
      if (ep == 0) begin
        reset_cycles = 4;
      end else begin
        reset_cycles = $urandom_range(8, 4);
      end
      set_bit = random_bit();
      run_episode(reset_cycles, set_bit);
    end

    $display("Ran %0d episodes, %0d of them after an aborted sequence",
             NUM_EPISODES, abort_count);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pcie_reconfig_top.f ====
hdl/reconfig_pkg.sv
hdl/pcie_reconfig_initiator.sv
hdl/reconfig_register_block.sv
hdl/pcie_reconfig_top.sv
verification/pcie_reconfig_chk.sv
verification/pcie_reconfig_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module pcie_reconfig_tb \
  -f pcie_reconfig_top.f

sim_out=$(./obj_dir/Vpcie_reconfig_tb 2>&1 || true)
echo "$sim_out"

if grep -q "PASS: all tests" <<< "$sim_out"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1
